/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_icache_subsys -f all.f
	./obj_dir/Vtb_icache_subsys > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
+incdir+include
rtl/fetch_pkg.sv
rtl/icache_interface.sv
rtl/icache_bank_dispatch.sv
rtl/icache_bank.sv
rtl/icache_resp_merge.sv
rtl/icache_subsys_top.sv
verif/icache_subsys_chk.sv
verif/tb_icache_subsys.sv

/* include/fetch_defines.svh */
// Size and latency macros for the fetch-side cache path, included by every design file
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Virtual address width of a fetch request
`define FETCH_ADDR_SIZE 40

// One cache line holds four 32-bit instruction words
`define FETCH_LINE_BITS 128

// Line storage is split over this many banks
`define FETCH_NUM_BANKS 4

// Lines held by one bank
// Index bits 11:4 give 256 lines, low two pick the bank
`define FETCH_BANK_ROWS 64

// Cycles from a bank read enable to its valid answer
`define FETCH_BANK_LAT 2

`endif

/* rtl/fetch_pkg.sv */
// Shared types of the fetch path, referenced by scoped name from the RTL and the checker
`include "fetch_defines.svh"

package fetch_pkg;

    // Number of 32-bit instruction words in one line
    localparam int unsigned LINE_WORDS = `FETCH_LINE_BITS / 32;

    // One cache line seen two ways
    // Banks and refill handle the raw vector
    // The interface picks one instruction out of the word array
    typedef union packed {
        logic [`FETCH_LINE_BITS-1:0]   raw;
        logic [LINE_WORDS-1:0][31:0]   words;
    } icache_line_t;

    // States of the fetch-facing FSM
    // ResetState is left after one cycle
    // NoReq and RespReady both accept a new request
    // ReqValid waits for the line answer
    typedef enum logic [1:0] {
        ResetState = 2'd0,
        NoReq      = 2'd1,
        ReqValid   = 2'd2,
        RespReady  = 2'd3
    } icache_state_t;

endpackage

/* rtl/icache_bank.sv */
// One bank of line storage with a write port and a fixed-latency pipelined read
`timescale 1ns/1ps
`include "fetch_defines.svh"

module icache_bank (
    input  logic                                clk_i,
    input  logic                                rstn_i,

    // Strobes from the dispatcher
    input  logic                                rd_en_i,
    input  logic                                wr_en_i,
    input  logic [$clog2(`FETCH_BANK_ROWS)-1:0] row_i,
    input  fetch_pkg::icache_line_t             wr_line_i,

    // Read answer towards the merger
    output logic                                rd_valid_o,
    output fetch_pkg::icache_line_t             rd_line_o
);

    // Line storage
    logic [`FETCH_LINE_BITS-1:0] mem [`FETCH_BANK_ROWS];

    // Read pipeline, stage 0 samples the storage
    logic                        vld_q  [`FETCH_BANK_LAT];
    fetch_pkg::icache_line_t     data_q [`FETCH_BANK_LAT];

    // Whole-line write
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[row_i] <= wr_line_i.raw;
        end
    end

    // Valid bits of the read pipeline
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < `FETCH_BANK_LAT; s++) begin
                vld_q[s] <= 1'b0;
            end
        end else begin
            vld_q[0] <= rd_en_i;
            for (int s = 1; s < `FETCH_BANK_LAT; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    // Line data moves along with its valid
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            data_q[0].raw <= mem[row_i];
        end
        for (int s = 1; s < `FETCH_BANK_LAT; s++) begin
            data_q[s] <= data_q[s-1];
        end
    end

    // Last stage is the answer
    assign rd_valid_o = vld_q[`FETCH_BANK_LAT-1];
    assign rd_line_o  = data_q[`FETCH_BANK_LAT-1];

endmodule

/* rtl/icache_bank_dispatch.sv */
// Routes line reads and refill writes to the bank picked by the low line-index bits
`timescale 1ns/1ps
`include "fetch_defines.svh"

module icache_bank_dispatch (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,

    // Line read from the interface
    input  logic                                        line_req_valid_i,
    input  logic [7:0]                                  line_req_idx_i,

    // Refill write from outside
    input  logic                                        fill_valid_i,
    input  logic [7:0]                                  fill_idx_i,
    input  fetch_pkg::icache_line_t                     fill_line_i,

    // Per-bank strobes and shared row and data
    output logic [`FETCH_NUM_BANKS-1:0]                 bank_rd_en_o,
    output logic [`FETCH_NUM_BANKS-1:0]                 bank_wr_en_o,
    output logic [$clog2(`FETCH_BANK_ROWS)-1:0]         bank_row_o,
    output fetch_pkg::icache_line_t                     bank_wr_line_o
);

    localparam int BANK_BITS = $clog2(`FETCH_NUM_BANKS);
    localparam int ROW_BITS  = $clog2(`FETCH_BANK_ROWS);
    localparam int CNT_BITS  = $clog2(`FETCH_BANK_LAT + 1);

    logic [BANK_BITS-1:0]        rd_bank;
    logic [BANK_BITS-1:0]        wr_bank;

    // Bank with a read in flight and cycles left on it
    logic [`FETCH_NUM_BANKS-1:0] rd_pend_q;
    logic [CNT_BITS-1:0]         rd_cnt_q;

    assign rd_bank = line_req_idx_i[BANK_BITS-1:0];
    assign wr_bank = fill_idx_i[BANK_BITS-1:0];

    // One-hot enables from the bank number
    always_comb begin
        for (int b = 0; b < `FETCH_NUM_BANKS; b++) begin
            bank_rd_en_o[b] = line_req_valid_i && (rd_bank == BANK_BITS'(b));
            bank_wr_en_o[b] = fill_valid_i && (wr_bank == BANK_BITS'(b));
        end
    end

    // Row is shared, refill and read never meet
    assign bank_row_o = fill_valid_i ? fill_idx_i[BANK_BITS +: ROW_BITS]
                                     : line_req_idx_i[BANK_BITS +: ROW_BITS];

    assign bank_wr_line_o = fill_line_i;

    // Outstanding read tracker, held until the bank answer is due
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_pend_q <= '0;
            rd_cnt_q  <= '0;
        end else if (line_req_valid_i) begin
            rd_pend_q <= bank_rd_en_o;
            rd_cnt_q  <= CNT_BITS'(`FETCH_BANK_LAT);
        end else if (rd_cnt_q != '0) begin
            rd_cnt_q <= rd_cnt_q - 1'b1;
            // Last cycle of the latency window
            if (rd_cnt_q == CNT_BITS'(1)) begin
                rd_pend_q <= '0;
            end
        end
    end

endmodule

/* rtl/icache_interface.sv */
// Fetch-facing front end: keeps the last line, answers hits at once and requests lines on miss
`timescale 1ns/1ps
`include "fetch_defines.svh"

module icache_interface (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    // Request from the fetch stage, held until answered
    input  logic                       fetch_req_valid_i,
    input  logic [`FETCH_ADDR_SIZE-1:0] fetch_vaddr_i,

    // Instruction access exception from translation
    input  logic                       tlb_xcp_if_i,

    // Line answer from the bank side
    input  logic                       line_resp_valid_i,
    input  fetch_pkg::icache_line_t    line_resp_line_i,

    // Line read towards the dispatcher
    output logic                       line_req_valid_o,
    output logic [7:0]                 line_req_idx_o,

    // Answer to the fetch stage
    output logic                       resp_valid_o,
    output logic [31:0]                resp_data_o,
    output logic                       resp_access_fault_o
);

    fetch_pkg::icache_state_t  state_q;
    fetch_pkg::icache_state_t  state_d;

    // Line buffer and the address it was fetched for
    fetch_pkg::icache_line_t   line_q;
    fetch_pkg::icache_line_t   line_int;
    logic [`FETCH_ADDR_SIZE-1:0] buf_addr_q;
    logic                      buf_valid_q;

    logic                      buf_miss;
    logic                      access_needed;

    // State register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= fetch_pkg::ResetState;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state, line request and response strobe
    always_comb begin
        case (state_q)
            fetch_pkg::ResetState: begin
                state_d          = fetch_pkg::NoReq;
                line_req_valid_o = 1'b0;
                resp_valid_o     = 1'b0;
            end
            fetch_pkg::NoReq, fetch_pkg::RespReady: begin
                // Hit answers now, miss goes off to the banks
                state_d          = access_needed ? fetch_pkg::ReqValid : fetch_pkg::NoReq;
                line_req_valid_o = access_needed;
                resp_valid_o     = fetch_req_valid_i & ~buf_miss & ~tlb_xcp_if_i;
            end
            fetch_pkg::ReqValid: begin
                // Wait for the merged bank answer
                state_d          = line_resp_valid_i ? fetch_pkg::RespReady : fetch_pkg::ReqValid;
                line_req_valid_o = 1'b0;
                resp_valid_o     = line_resp_valid_i & ~tlb_xcp_if_i;
            end
            default: begin
                state_d          = fetch_pkg::ResetState;
                line_req_valid_o = 1'b0;
                resp_valid_o     = 1'b0;
            end
        endcase
    end

    // Miss when nothing is buffered or the line part of the address differs
    assign buf_miss = ~buf_valid_q |
                      (buf_addr_q[`FETCH_ADDR_SIZE-1:4] != fetch_vaddr_i[`FETCH_ADDR_SIZE-1:4]);

    assign access_needed = fetch_req_valid_i & buf_miss;

    // Line index sent with the read
    assign line_req_idx_o = fetch_vaddr_i[11:4];

    // Fault mirrors the exception level
    assign resp_access_fault_o = tlb_xcp_if_i;

    // Buffer valid set by the first line answer
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            buf_valid_q <= 1'b0;
        end else if (line_resp_valid_i) begin
            buf_valid_q <= 1'b1;
        end
    end

    // Line and its address captured with every answer
    always_ff @(posedge clk_i) begin
        if (line_resp_valid_i) begin
            line_q     <= line_resp_line_i;
            buf_addr_q <= fetch_vaddr_i;
        end
    end

    // Fresh line bypasses the buffer in its arrival cycle
    assign line_int = line_resp_valid_i ? line_resp_line_i : line_q;

    // Word select by address bits 3:2
    assign resp_data_o = line_int.words[fetch_vaddr_i[3:2]];

endmodule

/* rtl/icache_resp_merge.sv */
// Folds the per-bank read answers into the single line answer seen by the interface
`timescale 1ns/1ps
`include "fetch_defines.svh"

module icache_resp_merge (
    // Answers from all banks
    input  logic [`FETCH_NUM_BANKS-1:0]  bank_rd_valid_i,
    input  fetch_pkg::icache_line_t      bank_rd_line_i [`FETCH_NUM_BANKS],

    // Merged answer
    output logic                         line_resp_valid_o,
    output fetch_pkg::icache_line_t      line_resp_line_o
);

    // Any bank answering makes a valid line
    assign line_resp_valid_o = |bank_rd_valid_i;

    // AND-OR select, only one bank answers at a time
    always_comb begin
        line_resp_line_o.raw = '0;
        for (int b = 0; b < `FETCH_NUM_BANKS; b++) begin
            line_resp_line_o.raw = line_resp_line_o.raw |
                ({`FETCH_LINE_BITS{bank_rd_valid_i[b]}} & bank_rd_line_i[b].raw);
        end
    end

endmodule

/* rtl/icache_subsys_top.sv */
// Top of the fetch path: interface, dispatcher, generated banks and answer merger
`timescale 1ns/1ps
`include "fetch_defines.svh"

module icache_subsys_top (
    input  logic                        clk_i,
    input  logic                        rstn_i,

    // Fetch request
    input  logic                        fetch_req_valid_i,
    input  logic [`FETCH_ADDR_SIZE-1:0] fetch_vaddr_i,
    input  logic                        tlb_xcp_if_i,

    // Refill port
    input  logic                        fill_valid_i,
    input  logic [7:0]                  fill_idx_i,
    input  fetch_pkg::icache_line_t     fill_line_i,

    // Fetch answer
    output logic                        resp_valid_o,
    output logic [31:0]                 resp_data_o,
    output logic                        resp_access_fault_o
);

    // Interface to dispatcher
    logic                                line_req_valid;
    logic [7:0]                          line_req_idx;

    // Dispatcher to banks
    logic [`FETCH_NUM_BANKS-1:0]         bank_rd_en;
    logic [`FETCH_NUM_BANKS-1:0]         bank_wr_en;
    logic [$clog2(`FETCH_BANK_ROWS)-1:0] bank_row;
    fetch_pkg::icache_line_t             bank_wr_line;

    // Banks to merger
    logic [`FETCH_NUM_BANKS-1:0]         bank_rd_valid;
    fetch_pkg::icache_line_t             bank_rd_line [`FETCH_NUM_BANKS];

    // Merger back to interface
    logic                                line_resp_valid;
    fetch_pkg::icache_line_t             line_resp_line;

    icache_interface u_interface (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .fetch_req_valid_i   (fetch_req_valid_i),
        .fetch_vaddr_i       (fetch_vaddr_i),
        .tlb_xcp_if_i        (tlb_xcp_if_i),
        .line_resp_valid_i   (line_resp_valid),
        .line_resp_line_i    (line_resp_line),
        .line_req_valid_o    (line_req_valid),
        .line_req_idx_o      (line_req_idx),
        .resp_valid_o        (resp_valid_o),
        .resp_data_o         (resp_data_o),
        .resp_access_fault_o (resp_access_fault_o)
    );

    icache_bank_dispatch u_dispatch (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .line_req_valid_i (line_req_valid),
        .line_req_idx_i   (line_req_idx),
        .fill_valid_i     (fill_valid_i),
        .fill_idx_i       (fill_idx_i),
        .fill_line_i      (fill_line_i),
        .bank_rd_en_o     (bank_rd_en),
        .bank_wr_en_o     (bank_wr_en),
        .bank_row_o       (bank_row),
        .bank_wr_line_o   (bank_wr_line)
    );

    // One storage bank per low index value
    for (genvar b = 0; b < `FETCH_NUM_BANKS; b++) begin : g_bank
        icache_bank u_bank (
            .clk_i      (clk_i),
            .rstn_i     (rstn_i),
            .rd_en_i    (bank_rd_en[b]),
            .wr_en_i    (bank_wr_en[b]),
            .row_i      (bank_row),
            .wr_line_i  (bank_wr_line),
            .rd_valid_o (bank_rd_valid[b]),
            .rd_line_o  (bank_rd_line[b])
        );
    end

    icache_resp_merge u_merge (
        .bank_rd_valid_i   (bank_rd_valid),
        .bank_rd_line_i    (bank_rd_line),
        .line_resp_valid_o (line_resp_valid),
        .line_resp_line_o  (line_resp_line)
    );

endmodule

/* verif/icache_subsys_chk.sv */
// Protocol assertions for the fetch path, bound into the dispatcher and the interface FSM
`timescale 1ns/1ps
`include "fetch_defines.svh"

module icache_subsys_chk (
    input logic                        clk_i,
    input logic                        rstn_i,
    input logic                        fill_valid_i,
    input logic                        line_req_valid_i,
    input logic [`FETCH_NUM_BANKS-1:0] rd_pend_i,
    input logic [`FETCH_NUM_BANKS-1:0] rd_en_i,
    input fetch_pkg::icache_state_t    state_i
);

    // Refill must not meet a pending or starting line read
    a_fill_no_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fill_valid_i |-> (rd_pend_i == '0) && !line_req_valid_i)
        else $error("refill issued while a line read is outstanding");

    // At most one bank read per cycle
    a_rd_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(rd_en_i))
        else $error("more than one bank read enable active");

    // No new line read while the FSM waits for one
    a_req_state: assert property (@(posedge clk_i) disable iff (!rstn_i)
        line_req_valid_i |-> state_i != fetch_pkg::ReqValid)
        else $error("line request issued in state ReqValid");

endmodule

// Dispatcher has no FSM, so its state input is tied to an idle state
bind icache_bank_dispatch icache_subsys_chk u_chk_dispatch (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .fill_valid_i     (fill_valid_i),
    .line_req_valid_i (line_req_valid_i),
    .rd_pend_i        (rd_pend_q),
    .rd_en_i          (bank_rd_en_o),
    .state_i          (fetch_pkg::NoReq)
);

// Interface sees no refill or bank strobes
bind icache_interface icache_subsys_chk u_chk_interface (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .fill_valid_i     (1'b0),
    .line_req_valid_i (line_req_valid_o),
    .rd_pend_i        ('0),
    .rd_en_i          ('0),
    .state_i          (state_q)
);

/* verif/tb_icache_subsys.sv */
// Self-checking testbench for the fetch path: refills known lines, fetches words, checks data and latency
`timescale 1ns/1ps
`include "fetch_defines.svh"

module tb_icache_subsys;

    localparam int TIMEOUT = 20;

    logic                        clk_i;
    logic                        rstn_i;
    logic                        fetch_req_valid_i;
    logic [`FETCH_ADDR_SIZE-1:0] fetch_vaddr_i;
    logic                        tlb_xcp_if_i;
    logic                        fill_valid_i;
    logic [7:0]                  fill_idx_i;
    fetch_pkg::icache_line_t     fill_line_i;
    logic                        resp_valid_o;
    logic [31:0]                 resp_data_o;
    logic                        resp_access_fault_o;

    // Expected contents of all 256 lines
    logic [`FETCH_LINE_BITS-1:0] model_mem [256];

    logic [31:0] lfsr_q;
    int          n_checks;
    int          n_errors;

    // Line the DUT should hold in its buffer
    logic [`FETCH_ADDR_SIZE-1:4] last_line;
    logic                        have_line;

    icache_subsys_top UUT (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .fetch_req_valid_i   (fetch_req_valid_i),
        .fetch_vaddr_i       (fetch_vaddr_i),
        .tlb_xcp_if_i        (tlb_xcp_if_i),
        .fill_valid_i        (fill_valid_i),
        .fill_idx_i          (fill_idx_i),
        .fill_line_i         (fill_line_i),
        .resp_valid_o        (resp_valid_o),
        .resp_data_o         (resp_data_o),
        .resp_access_fault_o (resp_access_fault_o)
    );

    // 8 ns clock
    always #4 clk_i = ~clk_i;

    // Expected word: line from index bits 11:4, word from bits 3:2
    function automatic logic [31:0] ref_word(input logic [`FETCH_ADDR_SIZE-1:0] addr);
        logic [`FETCH_LINE_BITS-1:0] line;
        line = model_mem[addr[11:4]];
        return line[int'(addr[3:2]) * 32 +: 32];
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit, newest bit at the bottom
    task automatic draw_bits(input int n, output logic [`FETCH_LINE_BITS-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[`FETCH_LINE_BITS-2:0], lfsr_q[0]};
        end
    endtask

    // Every answer is checked against the model at the held address
    always @(negedge clk_i) begin
        if (rstn_i && resp_valid_o) begin
            n_checks++;
            assert (resp_data_o == ref_word(fetch_vaddr_i))
            else begin
                n_errors++;
                $display("[FAIL] %0t resp_data_o got %08h expected %08h", $time,
                         resp_data_o, ref_word(fetch_vaddr_i));
            end
        end
    end

    // Counts cycles from the request until resp_valid_o
    task automatic wait_resp(output int waited);
        waited = 0;
        @(negedge clk_i);
        while (!resp_valid_o && waited < TIMEOUT) begin
            waited++;
            @(negedge clk_i);
        end
        if (!resp_valid_o) begin
            $display("Timeout: no response for address %h within %0d cycles",
                     fetch_vaddr_i, TIMEOUT);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    // Hit if the line matches the buffered one, else a full bank read
    task automatic fetch_word(input logic [`FETCH_ADDR_SIZE-1:0] addr);
        int waited;
        int exp_lat;
        exp_lat = (have_line && addr[`FETCH_ADDR_SIZE-1:4] == last_line) ? 0 : `FETCH_BANK_LAT;
        @(posedge clk_i);
        fetch_req_valid_i <= 1'b1;
        fetch_vaddr_i     <= addr;
        wait_resp(waited);
        n_checks += 2;
        assert (waited == exp_lat)
        else begin
            n_errors++;
            $display("[FAIL] %0t resp_valid_o latency for %h got %0d expected %0d", $time,
                     addr, waited, exp_lat);
        end
        assert (!resp_access_fault_o)
        else begin
            n_errors++;
            $display("[FAIL] %0t resp_access_fault_o got 1 expected 0", $time);
        end
        have_line = 1'b1;
        last_line = addr[`FETCH_ADDR_SIZE-1:4];
    endtask

    // One-cycle write strobe, model follows at once
    task automatic refill_line(input logic [7:0] idx, input logic [`FETCH_LINE_BITS-1:0] line);
        @(posedge clk_i);
        fill_valid_i    <= 1'b1;
        fill_idx_i      <= idx;
        fill_line_i.raw <= line;
        model_mem[idx]   = line;
        @(posedge clk_i);
        fill_valid_i    <= 1'b0;
    endtask

    task automatic report_test(input string name, input int err_mark);
        if (n_errors == err_mark) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, n_errors - err_mark);
        end
    endtask

    initial begin
        logic [`FETCH_LINE_BITS-1:0] r;
        logic [`FETCH_ADDR_SIZE-1:0] addr;
        logic [`FETCH_ADDR_SIZE-1:0] base;
        logic [7:0]                  idx;
        int                          err_mark;
        int                          waited;
        clk_i             = 1'b0;
        rstn_i            = 1'b0;
        fetch_req_valid_i = 1'b0;
        fetch_vaddr_i     = '0;
        tlb_xcp_if_i      = 1'b0;
        fill_valid_i      = 1'b0;
        fill_idx_i        = '0;
        fill_line_i       = '0;
        lfsr_q            = 32'h63ba7e0e;
        n_checks          = 0;
        n_errors          = 0;
        have_line         = 1'b0;
        last_line         = '0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;

        // Fill every line, then a cold miss
        err_mark = n_errors;
        for (int i = 0; i < 256; i++) begin
            draw_bits(`FETCH_LINE_BITS, r);
            refill_line(8'(i), r);
        end
        draw_bits(38, r);
        base = {r[37:0], 2'b00};
        fetch_word(base);
        report_test("cold miss", err_mark);

        // Other three words of the buffered line
        err_mark = n_errors;
        for (int w = 1; w < 4; w++) begin
            addr      = base;
            addr[3:2] = base[3:2] + 2'(w);
            fetch_word(addr);
        end
        report_test("buffer hit", err_mark);

        // One new line in each bank
        err_mark = n_errors;
        for (int b = 0; b < `FETCH_NUM_BANKS; b++) begin
            draw_bits(8, r);
            addr = {28'(32'h5a0 + b), r[7:2], 2'(b), r[1:0], 2'b00};
            fetch_word(addr);
        end
        report_test("line change", err_mark);

        // Exception held for four cycles over a miss
        err_mark = n_errors;
        draw_bits(8, r);
        addr = {28'h0c0ffee, r[7:0], 2'b01, 2'b00};
        @(posedge clk_i);
        fetch_req_valid_i <= 1'b1;
        fetch_vaddr_i     <= addr;
        tlb_xcp_if_i      <= 1'b1;
        repeat (4) begin
            @(negedge clk_i);
            n_checks += 2;
            assert (resp_access_fault_o)
            else begin
                n_errors++;
                $display("[FAIL] %0t resp_access_fault_o got 0 expected 1", $time);
            end
            assert (!resp_valid_o)
            else begin
                n_errors++;
                $display("[FAIL] %0t resp_valid_o got 1 expected 0", $time);
            end
        end
        @(posedge clk_i);
        tlb_xcp_if_i <= 1'b0;
        wait_resp(waited);
        // Line was captured while the fault was up
        have_line = 1'b1;
        last_line = addr[`FETCH_ADDR_SIZE-1:4];
        report_test("tlb exception", err_mark);

        // Mix of same-line words and fresh addresses
        err_mark = n_errors;
        for (int n = 0; n < 200; n++) begin
            draw_bits(1, r);
            if (r[0]) begin
                draw_bits(2, r);
                addr = {last_line, r[1:0], 2'b00};
            end else begin
                draw_bits(38, r);
                addr = {r[37:0], 2'b00};
            end
            fetch_word(addr);
        end
        report_test("random sweep", err_mark);

        // Rewrite a line that is not buffered, then miss on it
        err_mark = n_errors;
        @(posedge clk_i);
        fetch_req_valid_i <= 1'b0;
        idx = last_line[11:4] + 8'd1;
        draw_bits(`FETCH_LINE_BITS, r);
        refill_line(idx, r);
        addr = {last_line[`FETCH_ADDR_SIZE-1:12], idx, 2'b10, 2'b00};
        fetch_word(addr);
        report_test("refill update", err_mark);

        @(posedge clk_i);
        fetch_req_valid_i <= 1'b0;
        $display("Done: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
